// ==== hw/trans_pkg.sv ====
//************************************************
// Transfer unit package
// Widths, queue and buffer depths, and the
// descriptor and output beat types shared by the
// TX and RX paths of the DMA transfer unit
//************************************************

package trans_pkg;

   // Byte count of one transfer
   localparam int LEN_WIDTH = 15;

   // Both the TCDM and the EXT side move 64-bit words
   localparam int BEAT_BYTES = 8;
   localparam int DATA_WIDTH = BEAT_BYTES * 8;

   // Byte position inside one word
   localparam int OFF_WIDTH = 3;

   localparam int QUEUE_DEPTH = 2;
   localparam int BUFFER_DEPTH = 2;

   //**********************************************
   // Transfer descriptor, 21 bits
   //**********************************************
   typedef struct packed {
      logic [LEN_WIDTH-1:0] len;
      logic [OFF_WIDTH-1:0] tcdm_off;
      logic [OFF_WIDTH-1:0] ext_off;
   } trans_desc_t;

   //**********************************************
   // Output beat with byte strobes, 72 bits
   //**********************************************
   // Byte i of dat sits in bits 8i+7 to 8i and is valid when strb[i] is set
   typedef struct packed {
      logic [DATA_WIDTH-1:0] dat;
      logic [BEAT_BYTES-1:0] strb;
   } data_beat_t;

endpackage

// ==== hw/trans_fifo.sv ====
//************************************************
// Request/grant FIFO
// Register array with read and write pointers,
// used for descriptor queues and data buffers
//************************************************

`timescale 1ns/100ps

module trans_fifo #(
   parameter int WIDTH = 64,
   parameter int DEPTH = 2
) (
   input  logic             clk_i,
   input  logic             reset_i,

   input  logic             push_req_i,
   input  logic [WIDTH-1:0] push_dat_i,
   output logic             push_gnt_o,

   input  logic             pop_req_i,
   output logic [WIDTH-1:0] pop_dat_o,
   output logic             pop_gnt_o
);

   logic [WIDTH-1:0]         mem_q [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(DEPTH)-1:0] rd_ptr_q;
   logic [$clog2(DEPTH):0]   count_q;
   logic                     push_hs;
   logic                     pop_hs;

   // A full FIFO refuses a push even when a pop happens in the same cycle
   assign push_gnt_o = (count_q < DEPTH);
   assign pop_gnt_o  = (count_q != '0);
   assign pop_dat_o  = mem_q[rd_ptr_q];

   assign push_hs = push_req_i && push_gnt_o;
   assign pop_hs  = pop_req_i && pop_gnt_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_hs) begin
            wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_hs) begin
            rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push_hs && !pop_hs) begin
            count_q <= count_q + 1'b1;
         end else if (pop_hs && !push_hs) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Storage only, the pointers tell which entries are live
   always_ff @(posedge clk_i) begin
      if (push_hs) begin
         mem_q[wr_ptr_q] <= push_dat_i;
      end
   end

   assert property (@(posedge clk_i) disable iff (reset_i) count_q <= DEPTH);

   // A waiting word must not change under the consumer
   assert property (@(posedge clk_i) disable iff (reset_i)
      pop_gnt_o && !pop_req_i |=> pop_gnt_o && $stable(pop_dat_o));

endmodule

// ==== hw/trans_aligner.sv ====
//************************************************
// Transfer byte aligner
// Moves the bytes of one transfer from a source
// byte offset to a destination byte offset and
// marks the valid output bytes with strobes
//************************************************

`timescale 1ns/100ps

module trans_aligner (
   input  logic                              clk_i,
   input  logic                              reset_i,

   input  logic                              trans_req_i,
   input  logic [trans_pkg::LEN_WIDTH-1:0]   trans_len_i,
   input  logic [trans_pkg::OFF_WIDTH-1:0]   trans_src_off_i,
   input  logic [trans_pkg::OFF_WIDTH-1:0]   trans_dst_off_i,
   output logic                              trans_gnt_o,

   input  logic                              data_push_req_i,
   input  logic [trans_pkg::DATA_WIDTH-1:0]  data_push_dat_i,
   output logic                              data_push_gnt_o,

   input  logic                              data_pop_req_i,
   output trans_pkg::data_beat_t             data_pop_o,
   output logic                              data_pop_gnt_o
);

   typedef enum logic {
      IDLE,
      RUN
   } state_t;

   state_t                              state_q;
   logic [trans_pkg::LEN_WIDTH:0]       in_left_q;
   logic [trans_pkg::LEN_WIDTH:0]       out_left_q;
   logic                                skip_q;
   logic                                ready_q;
   logic                                first_q;
   logic [trans_pkg::OFF_WIDTH:0]       shift_q;
   logic [trans_pkg::OFF_WIDTH-1:0]     dst_off_q;
   logic [2*trans_pkg::DATA_WIDTH-1:0]  win_q;

   logic                                trans_hs;
   logic                                pop_hs;
   logic                                last_out;
   logic                                use_input;
   logic                                want_shift;
   logic                                shift_hs;
   logic [trans_pkg::LEN_WIDTH:0]       src_end;
   logic [trans_pkg::LEN_WIDTH:0]       dst_end;
   logic [trans_pkg::LEN_WIDTH:0]       in_words;
   logic [trans_pkg::OFF_WIDTH:0]       shift_d;
   logic [trans_pkg::DATA_WIDTH-1:0]    shift_in;
   logic [2*trans_pkg::DATA_WIDTH-1:0]  win_shifted;
   logic [trans_pkg::OFF_WIDTH:0]       tail_bytes;
   logic [trans_pkg::BEAT_BYTES-1:0]    strb_first;
   logic [trans_pkg::BEAT_BYTES-1:0]    strb_last;

   //**********************************************
   // Descriptor decode
   //**********************************************
   assign trans_gnt_o = (state_q == IDLE);
   assign trans_hs    = trans_req_i && trans_gnt_o;

   // Stream ends in bytes, counted from the start of the first word
   assign src_end = {1'b0, trans_len_i} +
                    {{(trans_pkg::LEN_WIDTH-2){1'b0}}, trans_src_off_i};
   assign dst_end = {1'b0, trans_len_i} +
                    {{(trans_pkg::LEN_WIDTH-2){1'b0}}, trans_dst_off_i};

   // Input words to consume, rounded up to whole words
   assign in_words = (src_end >> trans_pkg::OFF_WIDTH) +
                     {{trans_pkg::LEN_WIDTH{1'b0}}, |src_end[trans_pkg::OFF_WIDTH-1:0]};

   // Offset difference modulo 8; equal offsets take the upper window half
   assign shift_d = (trans_src_off_i == trans_dst_off_i) ?
                    (trans_pkg::OFF_WIDTH+1)'(trans_pkg::BEAT_BYTES) :
                    {1'b0, trans_src_off_i - trans_dst_off_i};

   //**********************************************
   // Window and output word
   //**********************************************
   // The window holds the newest word in its upper half. Output word m
   // needs the window to have moved m+1 times, or m+2 times when the
   // source offset is larger, since its bytes then straddle the next word.
   // Moves past the last input shift in zeros to flush the tail.
   assign last_out   = (out_left_q <= trans_pkg::BEAT_BYTES);
   assign use_input  = (in_left_q != '0);
   assign pop_hs     = data_pop_gnt_o && data_pop_req_i;
   assign want_shift = (state_q == RUN) && (!ready_q || (pop_hs && !last_out));
   assign shift_hs   = want_shift && (!use_input || data_push_req_i);
   assign shift_in   = use_input ? data_push_dat_i : '0;

   assign data_push_gnt_o = want_shift && use_input;
   assign data_pop_gnt_o  = (state_q == RUN) && ready_q;

   assign win_shifted = win_q >> {shift_q, 3'b000};

   // First word starts at the destination offset, last word ends early
   assign tail_bytes = out_left_q[trans_pkg::OFF_WIDTH:0];
   assign strb_first = first_q ? ({trans_pkg::BEAT_BYTES{1'b1}} << dst_off_q)
                               : {trans_pkg::BEAT_BYTES{1'b1}};
   assign strb_last  = last_out ?
                       ({trans_pkg::BEAT_BYTES{1'b1}} >>
                        ((trans_pkg::OFF_WIDTH+1)'(trans_pkg::BEAT_BYTES) - tail_bytes)) :
                       {trans_pkg::BEAT_BYTES{1'b1}};

   assign data_pop_o.dat  = win_shifted[trans_pkg::DATA_WIDTH-1:0];
   assign data_pop_o.strb = strb_first & strb_last;

   //**********************************************
   // Controller
   //**********************************************
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= IDLE;
         in_left_q  <= '0;
         out_left_q <= '0;
         skip_q     <= 1'b0;
         ready_q    <= 1'b0;
         first_q    <= 1'b0;
      end else begin
         if (trans_hs) begin
            state_q    <= RUN;
            in_left_q  <= in_words;
            out_left_q <= dst_end;
            skip_q     <= (trans_src_off_i > trans_dst_off_i);
            ready_q    <= 1'b0;
            first_q    <= 1'b1;
         end
         if (shift_hs) begin
            ready_q <= !skip_q;
            skip_q  <= 1'b0;
            if (use_input) begin
               in_left_q <= in_left_q - 1'b1;
            end
         end else if (pop_hs) begin
            ready_q <= 1'b0;
         end
         if (pop_hs) begin
            out_left_q <= out_left_q - (trans_pkg::LEN_WIDTH+1)'(trans_pkg::BEAT_BYTES);
            first_q    <= 1'b0;
            if (last_out) begin
               state_q <= IDLE;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (trans_hs) begin
         shift_q   <= shift_d;
         dst_off_q <= trans_dst_off_i;
      end
      if (shift_hs) begin
         win_q <= {shift_in, win_q[2*trans_pkg::DATA_WIDTH-1:trans_pkg::DATA_WIDTH]};
      end
   end

   // A zero length descriptor would leave the controller without an end
   assert property (@(posedge clk_i) disable iff (reset_i)
      trans_hs |-> trans_len_i != '0);

   // Word counts follow the descriptor, so no offered word is empty
   assert property (@(posedge clk_i) disable iff (reset_i)
      data_pop_gnt_o |-> |data_pop_o.strb);

endmodule

// ==== hw/trans_unit.sv ====
//************************************************
// DMA transfer unit
// Two independent paths: TX moves TCDM data to
// EXT, RX moves EXT data to TCDM. Each path is a
// descriptor queue, an input buffer, a byte
// aligner and an output buffer
//************************************************

`timescale 1ns/100ps

module trans_unit (
   input  logic                              clk_i,
   input  logic                              reset_i,

   // TX descriptors
   input  logic                              tx_trans_req_i,
   input  trans_pkg::trans_desc_t            tx_trans_i,
   output logic                              tx_trans_gnt_o,

   // TX data from TCDM
   input  logic                              tx_data_push_req_i,
   input  logic [trans_pkg::DATA_WIDTH-1:0]  tx_data_push_dat_i,
   output logic                              tx_data_push_gnt_o,

   // TX data to EXT
   input  logic                              tx_data_pop_req_i,
   output trans_pkg::data_beat_t             tx_data_pop_o,
   output logic                              tx_data_pop_gnt_o,

   // RX descriptors
   input  logic                              rx_trans_req_i,
   input  trans_pkg::trans_desc_t            rx_trans_i,
   output logic                              rx_trans_gnt_o,

   // RX data from EXT
   input  logic                              rx_data_push_req_i,
   input  logic [trans_pkg::DATA_WIDTH-1:0]  rx_data_push_dat_i,
   output logic                              rx_data_push_gnt_o,

   // RX data to TCDM
   input  logic                              rx_data_pop_req_i,
   output trans_pkg::data_beat_t             rx_data_pop_o,
   output logic                              rx_data_pop_gnt_o
);

   trans_pkg::trans_desc_t            tx_desc;
   logic                              tx_desc_valid;
   logic                              tx_desc_ready;
   logic [trans_pkg::DATA_WIDTH-1:0]  tx_in_dat;
   logic                              tx_in_valid;
   logic                              tx_in_ready;
   trans_pkg::data_beat_t             tx_out_beat;
   logic                              tx_out_valid;
   logic                              tx_out_ready;

   trans_pkg::trans_desc_t            rx_desc;
   logic                              rx_desc_valid;
   logic                              rx_desc_ready;
   logic [trans_pkg::DATA_WIDTH-1:0]  rx_in_dat;
   logic                              rx_in_valid;
   logic                              rx_in_ready;
   trans_pkg::data_beat_t             rx_out_beat;
   logic                              rx_out_valid;
   logic                              rx_out_ready;

   //**********************************************
   // TX path, TCDM to EXT
   //**********************************************
   trans_fifo #(
      .WIDTH ($bits(trans_pkg::trans_desc_t)),
      .DEPTH (trans_pkg::QUEUE_DEPTH)
   ) tx_trans_queue_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_req_i (tx_trans_req_i),
      .push_dat_i (tx_trans_i),
      .push_gnt_o (tx_trans_gnt_o),
      .pop_req_i  (tx_desc_ready),
      .pop_dat_o  (tx_desc),
      .pop_gnt_o  (tx_desc_valid)
   );

   trans_fifo #(
      .WIDTH (trans_pkg::DATA_WIDTH),
      .DEPTH (trans_pkg::BUFFER_DEPTH)
   ) tx_tcdm_buffer_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_req_i (tx_data_push_req_i),
      .push_dat_i (tx_data_push_dat_i),
      .push_gnt_o (tx_data_push_gnt_o),
      .pop_req_i  (tx_in_ready),
      .pop_dat_o  (tx_in_dat),
      .pop_gnt_o  (tx_in_valid)
   );

   trans_aligner tx_aligner_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .trans_req_i     (tx_desc_valid),
      .trans_len_i     (tx_desc.len),
      .trans_src_off_i (tx_desc.tcdm_off),
      .trans_dst_off_i (tx_desc.ext_off),
      .trans_gnt_o     (tx_desc_ready),
      .data_push_req_i (tx_in_valid),
      .data_push_dat_i (tx_in_dat),
      .data_push_gnt_o (tx_in_ready),
      .data_pop_req_i  (tx_out_ready),
      .data_pop_o      (tx_out_beat),
      .data_pop_gnt_o  (tx_out_valid)
   );

   trans_fifo #(
      .WIDTH ($bits(trans_pkg::data_beat_t)),
      .DEPTH (trans_pkg::BUFFER_DEPTH)
   ) tx_ext_buffer_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_req_i (tx_out_valid),
      .push_dat_i (tx_out_beat),
      .push_gnt_o (tx_out_ready),
      .pop_req_i  (tx_data_pop_req_i),
      .pop_dat_o  (tx_data_pop_o),
      .pop_gnt_o  (tx_data_pop_gnt_o)
   );

   //**********************************************
   // RX path, EXT to TCDM
   //**********************************************
   trans_fifo #(
      .WIDTH ($bits(trans_pkg::trans_desc_t)),
      .DEPTH (trans_pkg::QUEUE_DEPTH)
   ) rx_trans_queue_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_req_i (rx_trans_req_i),
      .push_dat_i (rx_trans_i),
      .push_gnt_o (rx_trans_gnt_o),
      .pop_req_i  (rx_desc_ready),
      .pop_dat_o  (rx_desc),
      .pop_gnt_o  (rx_desc_valid)
   );

   trans_fifo #(
      .WIDTH (trans_pkg::DATA_WIDTH),
      .DEPTH (trans_pkg::BUFFER_DEPTH)
   ) rx_ext_buffer_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_req_i (rx_data_push_req_i),
      .push_dat_i (rx_data_push_dat_i),
      .push_gnt_o (rx_data_push_gnt_o),
      .pop_req_i  (rx_in_ready),
      .pop_dat_o  (rx_in_dat),
      .pop_gnt_o  (rx_in_valid)
   );

   // On the RX path the EXT side is the source, so the offsets swap
   trans_aligner rx_aligner_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .trans_req_i     (rx_desc_valid),
      .trans_len_i     (rx_desc.len),
      .trans_src_off_i (rx_desc.ext_off),
      .trans_dst_off_i (rx_desc.tcdm_off),
      .trans_gnt_o     (rx_desc_ready),
      .data_push_req_i (rx_in_valid),
      .data_push_dat_i (rx_in_dat),
      .data_push_gnt_o (rx_in_ready),
      .data_pop_req_i  (rx_out_ready),
      .data_pop_o      (rx_out_beat),
      .data_pop_gnt_o  (rx_out_valid)
   );

   trans_fifo #(
      .WIDTH ($bits(trans_pkg::data_beat_t)),
      .DEPTH (trans_pkg::BUFFER_DEPTH)
   ) rx_tcdm_buffer_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_req_i (rx_out_valid),
      .push_dat_i (rx_out_beat),
      .push_gnt_o (rx_out_ready),
      .pop_req_i  (rx_data_pop_req_i),
      .pop_dat_o  (rx_data_pop_o),
      .pop_gnt_o  (rx_data_pop_gnt_o)
   );

endmodule

// ==== test/tb_trans_tasks.svh ====
//************************************************
// Transfer unit test tasks
// Reference byte model, drivers for descriptors
// and data words, output collector and checks
//************************************************

`ifndef TB_TRANS_TASKS_SVH
`define TB_TRANS_TASKS_SVH

// Pending stimulus and expected beats per path
trans_pkg::trans_desc_t            descs [2][4];
logic [trans_pkg::DATA_WIDTH-1:0]  in_words [2][16];
trans_pkg::data_beat_t             exp_beats [2][16];
int                                desc_cnt [2] = '{0, 0};
int                                in_cnt [2] = '{0, 0};
int                                exp_cnt [2] = '{0, 0};

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
   end
endtask

function automatic string path_name(input int p);
   return (p == 0) ? "tx" : "rx";
endfunction

function automatic logic [63:0] byte_mask(input logic [7:0] strb);
   logic [63:0] m;
   for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{strb[b]}};
   end
   return m;
endfunction

//**********************************************
// Reference model of the alignment rule
//**********************************************
task automatic add_transfer(input int p, input int len, input int tcdm_off,
                            input int ext_off);
   logic [7:0]             stream [64];
   trans_pkg::trans_desc_t d;
   trans_pkg::data_beat_t  beat;
   int                     src;
   int                     dst;
   int                     n_in;
   int                     n_out;
   int                     pos;
   // TX reads TCDM and writes EXT, RX the other way round
   src = (p == 0) ? tcdm_off : ext_off;
   dst = (p == 0) ? ext_off : tcdm_off;
   n_in = (src + len + 7) / 8;
   n_out = (dst + len + 7) / 8;
   d.len = (trans_pkg::LEN_WIDTH)'(len);
   d.tcdm_off = (trans_pkg::OFF_WIDTH)'(tcdm_off);
   d.ext_off = (trans_pkg::OFF_WIDTH)'(ext_off);
   descs[p][desc_cnt[p]] = d;
   desc_cnt[p]++;
   for (int w = 0; w < n_in; w++) begin
      for (int b = 0; b < 8; b++) begin
         stream[w*8 + b] = 8'($random(seed));
         in_words[p][in_cnt[p]][8*b +: 8] = stream[w*8 + b];
      end
      in_cnt[p]++;
   end
   for (int w = 0; w < n_out; w++) begin
      beat = '0;
      for (int b = 0; b < 8; b++) begin
         pos = w*8 + b;
         if (pos >= dst && pos < dst + len) begin
            beat.strb[b] = 1'b1;
            beat.dat[8*b +: 8] = stream[src + pos - dst];
         end
      end
      exp_beats[p][exp_cnt[p]] = beat;
      exp_cnt[p]++;
   end
endtask

//**********************************************
// Drivers and collector
//**********************************************
// Each loop drives just after a rising edge and looks at the grant
// at the falling edge, where it only depends on FIFO state
task automatic feed_descriptors(input int p);
   int i;
   i = 0;
   while (i < desc_cnt[p]) begin
      desc_req[p] = 1'b1;
      desc[p] = descs[p][i];
      @(negedge clk);
      if (desc_gnt[p]) begin
         i++;
      end
      @(posedge clk);
      #1;
   end
   desc_req[p] = 1'b0;
endtask

task automatic feed_words(input int p);
   int i;
   i = 0;
   while (i < in_cnt[p]) begin
      push_req[p] = 1'b1;
      push_dat[p] = in_words[p][i];
      @(negedge clk);
      if (push_gnt[p]) begin
         i++;
      end
      @(posedge clk);
      #1;
   end
   push_req[p] = 1'b0;
endtask

task automatic collect_beats(input int p, input bit stall);
   trans_pkg::data_beat_t got;
   trans_pkg::data_beat_t exp;
   logic [63:0]           mask;
   int                    idx;
   idx = 0;
   while (idx < exp_cnt[p]) begin
      pop_req[p] = stall ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      if (pop_req[p] && pop_gnt[p]) begin
         got = pop_beat[p];
         exp = exp_beats[p][idx];
         mask = byte_mask(exp.strb);
         check_value({path_name(p), "_data_pop_o.strb"}, 64'(got.strb), 64'(exp.strb));
         check_value({path_name(p), "_data_pop_o.dat"}, got.dat & mask, exp.dat & mask);
         idx++;
      end
      @(posedge clk);
      #1;
   end
   pop_req[p] = 1'b0;
endtask

task automatic run_paths(input bit stall);
   fork
      feed_descriptors(0);
      feed_descriptors(1);
      feed_words(0);
      feed_words(1);
      collect_beats(0, stall);
      collect_beats(1, stall);
   join
   // A word left behind here would be a duplicated or extra beat
   repeat (4) @(posedge clk);
   #1;
   for (int p = 0; p < 2; p++) begin
      check_value({path_name(p), "_data_pop_gnt_o"}, 64'(pop_gnt[p]), 64'(0));
      desc_cnt[p] = 0;
      in_cnt[p] = 0;
      exp_cnt[p] = 0;
   end
endtask

//**********************************************
// Directed tests
//**********************************************
task automatic check_reset_state();
   for (int p = 0; p < 2; p++) begin
      check_value({path_name(p), "_trans_gnt_o"}, 64'(desc_gnt[p]), 64'(1));
      check_value({path_name(p), "_data_push_gnt_o"}, 64'(push_gnt[p]), 64'(1));
      check_value({path_name(p), "_data_pop_gnt_o"}, 64'(pop_gnt[p]), 64'(0));
   end
endtask

task automatic aligned_tx_transfer();
   add_transfer(0, 16, 0, 0);
   run_paths(1'b0);
endtask

task automatic unaligned_tx_transfers();
   add_transfer(0, 13, 3, 5);
   run_paths(1'b0);
   add_transfer(0, 20, 6, 1);
   run_paths(1'b0);
   // Single byte inside one word
   add_transfer(0, 1, 2, 2);
   run_paths(1'b0);
endtask

task automatic rx_swapped_offsets();
   add_transfer(1, 9, 0, 7);
   run_paths(1'b0);
endtask

task automatic concurrent_stalled_paths();
   add_transfer(0, 11, 5, 2);
   add_transfer(0, 17, 0, 6);
   add_transfer(1, 14, 1, 4);
   add_transfer(1, 8, 7, 0);
   run_paths(1'b1);
endtask

`endif

// ==== test/tb_trans_unit.sv ====
//************************************************
// Testbench for the DMA transfer unit
// Clock, reset, DUT, watchdog and the sequence
// of directed tests on the TX and RX paths
//************************************************

`timescale 1ns/100ps

module tb_trans_unit;

   localparam int CLK_PERIOD = 10;
   localparam int NUM_TESTS = 5;
   // Sum of all transfer lengths in the directed tests
   localparam int TOTAL_BYTES = 109;
   localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS + 20 * TOTAL_BYTES;

   logic clk;
   logic reset;

   // Index 0 is the TX path, index 1 is the RX path
   logic                              desc_req [2];
   trans_pkg::trans_desc_t            desc [2];
   logic                              desc_gnt [2];
   logic                              push_req [2];
   logic [trans_pkg::DATA_WIDTH-1:0]  push_dat [2];
   logic                              push_gnt [2];
   logic                              pop_req [2];
   trans_pkg::data_beat_t             pop_beat [2];
   logic                              pop_gnt [2];

   integer seed = 32'hb0d5;
   int     errors = 0;
   int     checks = 0;

   `include "tb_trans_tasks.svh"

   trans_unit dut (
      .clk_i              (clk),
      .reset_i            (reset),
      .tx_trans_req_i     (desc_req[0]),
      .tx_trans_i         (desc[0]),
      .tx_trans_gnt_o     (desc_gnt[0]),
      .tx_data_push_req_i (push_req[0]),
      .tx_data_push_dat_i (push_dat[0]),
      .tx_data_push_gnt_o (push_gnt[0]),
      .tx_data_pop_req_i  (pop_req[0]),
      .tx_data_pop_o      (pop_beat[0]),
      .tx_data_pop_gnt_o  (pop_gnt[0]),
      .rx_trans_req_i     (desc_req[1]),
      .rx_trans_i         (desc[1]),
      .rx_trans_gnt_o     (desc_gnt[1]),
      .rx_data_push_req_i (push_req[1]),
      .rx_data_push_dat_i (push_dat[1]),
      .rx_data_push_gnt_o (push_gnt[1]),
      .rx_data_pop_req_i  (pop_req[1]),
      .rx_data_pop_o      (pop_beat[1]),
      .rx_data_pop_gnt_o  (pop_gnt[1])
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //**********************************************
   // Test sequence
   //**********************************************
   initial begin
      reset = 1'b1;
      for (int p = 0; p < 2; p++) begin
         desc_req[p] = 1'b0;
         desc[p]     = '0;
         push_req[p] = 1'b0;
         push_dat[p] = '0;
         pop_req[p]  = 1'b0;
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      check_reset_state();
      aligned_tx_transfer();
      unaligned_tx_transfers();
      rx_swapped_offsets();
      concurrent_stalled_paths();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Stops a run that hangs on a lost handshake
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("ERROR: run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("tests failed");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+test
hw/trans_pkg.sv
hw/trans_fifo.sv
hw/trans_aligner.sv
hw/trans_unit.sv
test/tb_trans_unit.sv
